// File: filelist.f
logic/dcore_dims_pkg.sv
logic/dcore_ctl_pkg.sv
logic/adc_unfold.sv
logic/rx_bit_select.sv
logic/prbs_generator.sv
logic/prbs_checker.sv
logic/digital_core.sv
test/tb_clock_gen.sv
test/tb_digital_core.sv

// File: test/tb_digital_core.sv
`timescale 1ns/1ns

module tb_digital_core
    import dcore_dims_pkg::*, dcore_ctl_pkg::*;
();

    localparam int NTI    = NTI_DEF;
    localparam int NADC   = NADC_DEF;
    localparam int NPRBS  = NPRBS_DEF;
    localparam int NCOUNT = NCOUNT_DEF;

    // x7 + x6 + 1 with taps at state bits 6 and 5
    localparam logic [NPRBS-1:0] EQN = 7'b110_0000;

    // phase lengths in cycles set the timeout
    localparam int RST_CYCLES   = 4;
    localparam int UNF_CYCLES   = 200;
    localparam int LOOP_CYCLES  = 300;
    localparam int SETTLE       = 12;
    localparam int PHASE_CYCLES = 4 * SETTLE;
    localparam int TEST_CYCLES  = RST_CYCLES + UNF_CYCLES + LOOP_CYCLES + 5 * PHASE_CYCLES;
    localparam int TIMEOUT      = 2 * TEST_CYCLES;

    logic                   clk_adc;
    logic                   rstb;
    logic        [NADC-1:0] adc_mag      [NTI-1:0];
    logic        [NTI-1:0]  adc_sign;
    logic signed [NADC-1:0] pfd_offset   [NTI-1:0];
    logic signed [NADC-1:0] adc_thresh;
    rx_src_t                src_sel;
    logic                   gen_en;
    logic       [NPRBS-1:0] gen_init;
    logic                   gen_inj_err;
    logic                   chk_en;
    logic        [NTI-1:0]  chan_sel;
    logic                   count_clr;
    logic signed [NADC-1:0] adc_unfolded [NTI-1:0];
    logic      [NCOUNT-1:0] err_count;
    logic      [NCOUNT-1:0] bit_count;
    logic        [NTI-1:0]  prbs_flags;

    logic [31:0]            rng;
    logic [NPRBS-1:0]       model;
    logic                   adc_drive;
    logic                   quiet_mode;
    int                     bad_lanes;
    int                     cycle_cnt;
    int                     fail_count;

    // expectations latched on the sampling edge
    logic signed [NADC-1:0] exp_unf [NTI-1:0];
    logic        [NTI-1:0]  sel_seen;
    logic                   quiet_seen;
    logic                   live;

    // lanes that raised a flag since the last clear
    logic        [NTI-1:0]  flags_seen;

    tb_clock_gen #(
        .RST_CYCLES(RST_CYCLES)
    ) i_clock_gen (
        .clk_adc(clk_adc),
        .rstb   (rstb)
    );

    digital_core i_digital_core (
        .clk_adc       (clk_adc),
        .rstb          (rstb),
        .adc_mag_i     (adc_mag),
        .adc_sign_i    (adc_sign),
        .pfd_offset_i  (pfd_offset),
        .adc_thresh_i  (adc_thresh),
        .src_sel_i     (src_sel),
        .gen_en_i      (gen_en),
        .gen_init_i    (gen_init),
        .gen_eqn_i     (EQN),
        .gen_inj_err_i (gen_inj_err),
        .chk_en_i      (chk_en),
        .chk_eqn_i     (EQN),
        .chan_sel_i    (chan_sel),
        .count_clr_i   (count_clr),
        .adc_unfolded_o(adc_unfolded),
        .err_count_o   (err_count),
        .bit_count_o   (bit_count),
        .prbs_flags_o  (prbs_flags)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // signed magnitude minus offset wrapped to NADC bits
    function automatic logic signed [NADC-1:0] unfold_ref(
        input logic        [NADC-1:0] mag,
        input logic                   sign,
        input logic signed [NADC-1:0] off
    );
        int v;
        v = sign ? int'(mag) : -int'(mag);
        v = v - int'(off);
        return v[NADC-1:0];
    endfunction

    function automatic logic slice_ref(
        input logic signed [NADC-1:0] code,
        input logic signed [NADC-1:0] thresh
    );
        return int'(code) > int'(thresh);
    endfunction

    // fibonacci step with the newest bit in position 0
    function automatic logic [NPRBS-1:0] prbs_step(input logic [NPRBS-1:0] s);
        return {s[NPRBS-2:0], ^(s & EQN)};
    endfunction

    // a flipped bit is seen once directly and once per tap
    function automatic int inj_errors(input int lanes);
        return lanes * (1 + $countones(EQN));
    endfunction

    //////////////////////////////
    // error reporting
    //////////////////////////////

    task automatic stop_run(input string why);
        fail_count++;
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input longint got, input longint exp);
        stop_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                           $time, name, got, exp));
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////

    always @(posedge clk_adc) begin
        for (int k = 0; k < NTI; k++) begin
            exp_unf[k] = unfold_ref(adc_mag[k], adc_sign[k], pfd_offset[k]);
        end
        sel_seen   = chan_sel;
        quiet_seen = quiet_mode;
        live       = rstb;
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            stop_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT));
        end
    end

    always @(negedge clk_adc) begin
        if (live) begin
            for (int k = 0; k < NTI; k++) begin
                assert (adc_unfolded[k] === exp_unf[k])
                else report_mismatch($sformatf("adc_unfolded_o[%0d]", k),
                                     adc_unfolded[k], exp_unf[k]);
            end
            // deselected lanes never flag
            assert ((prbs_flags & ~sel_seen) == '0)
            else report_mismatch("prbs_flags_o", prbs_flags, prbs_flags & sel_seen);
            flags_seen = flags_seen | prbs_flags;
            if (quiet_seen) begin
                assert (err_count == '0)
                else report_mismatch("err_count_o", err_count, 0);
                assert (prbs_flags == '0)
                else report_mismatch("prbs_flags_o", prbs_flags, 0);
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one cycle of stimulus
    // in adc mode the signs follow the prbs model
    task automatic tick(input logic invert);
        if (adc_drive) begin
            model = prbs_step(model);
            for (int k = 0; k < NTI; k++) begin
                rng = xorshift(rng);
                // odd and below half scale so never zero
                adc_mag[k]  = {1'b0, rng[NADC-2:1], 1'b1};
                adc_sign[k] = model[0] ^ invert;
                if (slice_ref(unfold_ref(adc_mag[k], adc_sign[k], pfd_offset[k]), adc_thresh)
                        != model[0]) begin
                    bad_lanes++;
                end
            end
        end
        @(negedge clk_adc);
    endtask

    task automatic step(input int n);
        repeat (n) tick(1'b0);
    endtask

    task automatic clear_counters();
        count_clr = 1'b1;
        tick(1'b0);
        count_clr = 1'b0;
        assert (err_count == '0)
        else report_mismatch("err_count_o", err_count, 0);
        assert (bit_count == '0)
        else report_mismatch("bit_count_o", bit_count, 0);
    endtask

    task automatic expect_errors(input longint exp);
        assert (err_count == exp)
        else report_mismatch("err_count_o", err_count, exp);
    endtask

    task automatic injection_run();
        clear_counters();
        flags_seen = '0;
        step(SETTLE);
        gen_inj_err = 1'b1;
        tick(1'b0);
        gen_inj_err = 1'b0;
        step(SETTLE);
        expect_errors(inj_errors($countones(chan_sel)));
        // every selected lane sees the flipped bit
        assert (flags_seen == chan_sel)
        else report_mismatch("prbs_flags_o", flags_seen, chan_sel);
    endtask

    initial begin
        rng         = 32'd3;
        model       = 7'h5a;
        adc_drive   = 1'b0;
        quiet_mode  = 1'b0;
        bad_lanes   = 0;
        cycle_cnt   = 0;
        fail_count  = 0;
        live        = 1'b0;
        flags_seen  = '0;
        adc_sign    = '0;
        adc_thresh  = '0;
        src_sel     = RX_SRC_ADC;
        gen_en      = 1'b0;
        gen_init    = 7'h01;
        gen_inj_err = 1'b0;
        chk_en      = 1'b0;
        chan_sel    = '1;
        count_clr   = 1'b0;
        for (int k = 0; k < NTI; k++) begin
            adc_mag[k]    = '0;
            pfd_offset[k] = '0;
        end
        @(posedge rstb);

        // random codes through the unfolding stage
        for (int c = 0; c < UNF_CYCLES; c++) begin
            for (int k = 0; k < NTI; k++) begin
                rng = xorshift(rng);
                adc_mag[k]    = rng[NADC-1:0];
                adc_sign[k]   = rng[NADC];
                pfd_offset[k] = rng[16 +: NADC];
            end
            tick(1'b0);
        end

        // clean bist loop on all lanes
        src_sel = RX_SRC_BIST;
        gen_en  = 1'b1;
        chk_en  = 1'b1;
        step(SETTLE);
        clear_counters();
        quiet_mode = 1'b1;
        step(LOOP_CYCLES);
        quiet_mode = 1'b0;
        // counting resumes once the history has refilled after the clear
        assert (bit_count == (LOOP_CYCLES - NPRBS) * NTI)
        else report_mismatch("bit_count_o", bit_count, (LOOP_CYCLES - NPRBS) * NTI);

        // single injection then again under a random lane mask
        injection_run();
        rng      = xorshift(rng);
        chan_sel = rng[NTI-1:0];
        injection_run();

        // adc path carrying the model sequence
        chan_sel = '1;
        for (int k = 0; k < NTI; k++) begin
            pfd_offset[k] = '0;
        end
        src_sel   = RX_SRC_ADC;
        adc_drive = 1'b1;
        step(SETTLE);
        clear_counters();
        step(SETTLE);
        quiet_mode = 1'b1;
        step(SETTLE);
        quiet_mode = 1'b0;
        bad_lanes  = 0;
        tick(1'b1);
        step(SETTLE);
        expect_errors(inj_errors(bad_lanes));

        if (fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run("errors were recorded during the run");
        end
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES  = 4
) (
    output logic clk_adc,
    output logic rstb
);

    initial begin
        clk_adc = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_adc = ~clk_adc;
        end
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rstb = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_adc);
        @(negedge clk_adc);
        rstb = 1'b1;
    end

endmodule

// File: logic/digital_core.sv
`timescale 1ns/1ns
`default_nettype none

module digital_core import dcore_dims_pkg::*, dcore_ctl_pkg::*; #(
    parameter int Nti    = NTI_DEF,
    parameter int Nadc   = NADC_DEF,
    parameter int Nprbs  = NPRBS_DEF,
    parameter int Ncount = NCOUNT_DEF
) (
    input  wire logic                   clk_adc,
    input  wire logic                   rstb,

    // adc samples
    input  wire logic        [Nadc-1:0] adc_mag_i      [Nti-1:0],
    input  wire logic        [Nti-1:0]  adc_sign_i,
    input  wire logic signed [Nadc-1:0] pfd_offset_i   [Nti-1:0],
    input  wire logic signed [Nadc-1:0] adc_thresh_i,
    input  wire rx_src_t                src_sel_i,

    // bist generator
    input  wire logic                   gen_en_i,
    input  wire logic       [Nprbs-1:0] gen_init_i,
    input  wire logic       [Nprbs-1:0] gen_eqn_i,
    input  wire logic                   gen_inj_err_i,

    // checker
    input  wire logic                   chk_en_i,
    input  wire logic       [Nprbs-1:0] chk_eqn_i,
    input  wire logic        [Nti-1:0]  chan_sel_i,
    input  wire logic                   count_clr_i,

    output logic      signed [Nadc-1:0] adc_unfolded_o [Nti-1:0],
    output logic           [Ncount-1:0] err_count_o,
    output logic           [Ncount-1:0] bit_count_o,
    output logic             [Nti-1:0]  prbs_flags_o
);

    logic           bist_bit;
    logic [Nti-1:0] rx_bits;

    //////////////////////////////
    // adc path
    //////////////////////////////

    adc_unfold #(
        .Nti (Nti),
        .Nadc(Nadc)
    ) i_adc_unfold (
        .clk_adc       (clk_adc),
        .rstb          (rstb),
        .adc_mag_i     (adc_mag_i),
        .adc_sign_i    (adc_sign_i),
        .pfd_offset_i  (pfd_offset_i),
        .adc_unfolded_o(adc_unfolded_o)
    );

    // slicer and source mux
    rx_bit_select #(
        .Nti (Nti),
        .Nadc(Nadc)
    ) i_rx_bit_select (
        .clk_adc     (clk_adc),
        .rstb        (rstb),
        .codes_i     (adc_unfolded_o),
        .adc_thresh_i(adc_thresh_i),
        .bist_bit_i  (bist_bit),
        .src_sel_i   (src_sel_i),
        .rx_bits_o   (rx_bits)
    );

    //////////////////////////////
    // prbs
    //////////////////////////////

    prbs_generator #(
        .Nprbs(Nprbs)
    ) i_prbs_generator (
        .clk_adc      (clk_adc),
        .rstb         (rstb),
        .gen_en_i     (gen_en_i),
        .gen_init_i   (gen_init_i),
        .gen_eqn_i    (gen_eqn_i),
        .gen_inj_err_i(gen_inj_err_i),
        .bist_bit_o   (bist_bit)
    );

    prbs_checker #(
        .Nti   (Nti),
        .Nprbs (Nprbs),
        .Ncount(Ncount)
    ) i_prbs_checker (
        .clk_adc     (clk_adc),
        .rstb        (rstb),
        .chk_en_i    (chk_en_i),
        .chk_eqn_i   (chk_eqn_i),
        .chan_sel_i  (chan_sel_i),
        .count_clr_i (count_clr_i),
        .rx_bits_i   (rx_bits),
        .err_count_o (err_count_o),
        .bit_count_o (bit_count_o),
        .prbs_flags_o(prbs_flags_o)
    );

endmodule

`default_nettype wire

// File: logic/prbs_checker.sv
`timescale 1ns/1ns
`default_nettype none

module prbs_checker import dcore_dims_pkg::*; #(
    parameter int Nti    = NTI_DEF,
    parameter int Nprbs  = NPRBS_DEF,
    parameter int Ncount = NCOUNT_DEF
) (
    input  wire logic              clk_adc,
    input  wire logic              rstb,

    // control
    input  wire logic              chk_en_i,
    input  wire logic [Nprbs-1:0]  chk_eqn_i,
    input  wire logic [Nti-1:0]    chan_sel_i,
    input  wire logic              count_clr_i,

    // received bits, one per lane
    input  wire logic [Nti-1:0]    rx_bits_i,

    output logic      [Ncount-1:0] err_count_o,
    output logic      [Ncount-1:0] bit_count_o,
    output logic      [Nti-1:0]    prbs_flags_o
);

    localparam int Nwarm = $clog2(Nprbs + 1);
    localparam int Npop  = $clog2(Nti + 1);

    // last Nprbs bits per lane, newest in bit 0
    logic [Nprbs-1:0] hist [Nti-1:0];

    logic [Nti-1:0]   mismatch;
    logic [Nwarm-1:0] warm_cnt;
    logic             warm_done;
    logic             count_en;
    logic [Npop-1:0]  err_pop;
    logic [Npop-1:0]  sel_pop;

    function automatic logic [Npop-1:0] popcount(input logic [Nti-1:0] v);
        logic [Npop-1:0] n;
        n = '0;
        for (int i = 0; i < Nti; i++) begin
            n = n + Npop'(v[i]);
        end
        return n;
    endfunction

    //////////////////////////////
    // prediction
    //////////////////////////////

    // self-synchronizing: the lane's own history predicts the next bit
    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            mismatch[k] = rx_bits_i[k] ^ (^(hist[k] & chk_eqn_i));
        end
    end

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            for (int k = 0; k < Nti; k++) begin
                hist[k] <= '0;
            end
        end else if (chk_en_i) begin
            for (int k = 0; k < Nti; k++) begin
                hist[k] <= {hist[k][Nprbs-2:0], rx_bits_i[k]};
            end
        end
    end

    //////////////////////////////
    // warm-up
    //////////////////////////////

    // history must be refilled after enable rises or a clear
    assign warm_done = (warm_cnt == Nwarm'(Nprbs));
    assign count_en  = chk_en_i && warm_done;

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            warm_cnt <= '0;
        end else if (count_clr_i || !chk_en_i) begin
            warm_cnt <= '0;
        end else if (!warm_done) begin
            warm_cnt <= warm_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // counters and flags
    //////////////////////////////

    assign err_pop = popcount(mismatch & chan_sel_i);
    assign sel_pop = popcount(chan_sel_i);

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            err_count_o <= '0;
            bit_count_o <= '0;
        end else if (count_clr_i) begin
            err_count_o <= '0;
            bit_count_o <= '0;
        end else if (count_en) begin
            err_count_o <= err_count_o + Ncount'(err_pop);
            bit_count_o <= bit_count_o + Ncount'(sel_pop);
        end
    end

    // flags quiet during warm-up, history is not valid yet
    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            prbs_flags_o <= '0;
        end else if (count_en) begin
            prbs_flags_o <= mismatch & chan_sel_i;
        end else begin
            prbs_flags_o <= '0;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // every counted error is also a counted bit
    a_err_le_total : assert property (
        @(posedge clk_adc) disable iff (!rstb)
        err_count_o <= bit_count_o
    );

    // clear is a single-cycle strobe
    a_clr_strobe : assert property (
        @(posedge clk_adc) disable iff (!rstb)
        count_clr_i |=> !count_clr_i
    );

endmodule

`default_nettype wire

// File: logic/prbs_generator.sv
`timescale 1ns/1ns
`default_nettype none

module prbs_generator import dcore_dims_pkg::*; #(
    parameter int Nprbs = NPRBS_DEF
) (
    input  wire logic             clk_adc,
    input  wire logic             rstb,

    // low: load gen_init_i, high: run
    input  wire logic             gen_en_i,
    input  wire logic [Nprbs-1:0] gen_init_i,

    // tap mask, bit i set means state bit i feeds back
    input  wire logic [Nprbs-1:0] gen_eqn_i,

    // one-cycle pulse flips one output bit
    input  wire logic             gen_inj_err_i,

    output logic                  bist_bit_o
);

    logic [Nprbs-1:0] state;
    logic             feedback;

    // fibonacci feedback, parity of the tapped bits
    assign feedback = ^(state & gen_eqn_i);

    //////////////////////////////
    // lfsr state
    //////////////////////////////

    // newest bit sits in position 0
    // injected errors never reach the state, so the sequence resumes cleanly
    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            state <= '0;
        end else if (!gen_en_i) begin
            state <= gen_init_i;
        end else begin
            state <= {state[Nprbs-2:0], feedback};
        end
    end

    // output bit
    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            bist_bit_o <= 1'b0;
        end else if (!gen_en_i) begin
            bist_bit_o <= 1'b0;
        end else begin
            bist_bit_o <= feedback ^ gen_inj_err_i;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // an empty tap mask would lock the lfsr at a constant
    a_eqn_nonzero : assert property (
        @(posedge clk_adc) disable iff (!rstb)
        gen_en_i |-> (gen_eqn_i != '0)
    );

endmodule

`default_nettype wire

// File: logic/rx_bit_select.sv
`timescale 1ns/1ns
`default_nettype none

module rx_bit_select import dcore_dims_pkg::*, dcore_ctl_pkg::*; #(
    parameter int Nti  = NTI_DEF,
    parameter int Nadc = NADC_DEF
) (
    input  wire logic                   clk_adc,
    input  wire logic                   rstb,

    // unfolded codes from adc_unfold
    input  wire logic signed [Nadc-1:0] codes_i [Nti-1:0],
    input  wire logic signed [Nadc-1:0] adc_thresh_i,

    // bist bit, same for every lane
    input  wire logic                   bist_bit_i,
    input  wire rx_src_t                src_sel_i,

    output logic             [Nti-1:0]  rx_bits_o
);

    logic [Nti-1:0] sliced;
    logic [Nti-1:0] chosen;

    //////////////////////////////
    // slicer
    //////////////////////////////

    // strict compare, a code equal to the threshold slices to 0
    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            sliced[k] = (codes_i[k] > adc_thresh_i);
        end
    end

    // source mux
    always_comb begin
        if (src_sel_i == RX_SRC_BIST) begin
            chosen = {Nti{bist_bit_i}};
        end else begin
            chosen = sliced;
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            rx_bits_o <= '0;
        end else begin
            rx_bits_o <= chosen;
        end
    end

endmodule

`default_nettype wire

// File: logic/adc_unfold.sv
`timescale 1ns/1ns
`default_nettype none

module adc_unfold import dcore_dims_pkg::*; #(
    parameter int Nti  = NTI_DEF,
    parameter int Nadc = NADC_DEF
) (
    input  wire logic                   clk_adc,
    input  wire logic                   rstb,

    // raw adc sample per lane
    input  wire logic        [Nadc-1:0] adc_mag_i      [Nti-1:0],
    input  wire logic        [Nti-1:0]  adc_sign_i,

    // per-lane pfd offset, applied after the sign
    input  wire logic signed [Nadc-1:0] pfd_offset_i   [Nti-1:0],

    output logic      signed [Nadc-1:0] adc_unfolded_o [Nti-1:0]
);

    // sign applied to the magnitude
    logic signed [Nadc-1:0] signed_code [Nti-1:0];

    // offset removed, before the output register
    logic signed [Nadc-1:0] corrected   [Nti-1:0];

    //////////////////////////////
    // unfolding
    //////////////////////////////

    // sign bit high keeps the magnitude, low negates it
    // everything wraps at Nadc bits
    always_comb begin
        for (int k = 0; k < Nti; k++) begin
            if (adc_sign_i[k]) begin
                signed_code[k] = adc_mag_i[k];
            end else begin
                signed_code[k] = -adc_mag_i[k];
            end
            corrected[k] = signed_code[k] - pfd_offset_i[k];
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk_adc or negedge rstb) begin
        if (!rstb) begin
            for (int k = 0; k < Nti; k++) begin
                adc_unfolded_o[k] <= '0;
            end
        end else begin
            for (int k = 0; k < Nti; k++) begin
                adc_unfolded_o[k] <= corrected[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dcore_ctl_pkg.sv
package dcore_ctl_pkg;

    //////////////////////////////
    // receive-bit source select
    //////////////////////////////

    // adc: sliced unfolded codes
    // bist: generator bit copied to every lane
    typedef enum logic {
        RX_SRC_ADC  = 1'b0,
        RX_SRC_BIST = 1'b1
    } rx_src_t;

endpackage

// File: logic/dcore_dims_pkg.sv
package dcore_dims_pkg;

    //////////////////////////////
    // datapath sizes
    //////////////////////////////

    // interleaved lanes delivered per clk_adc cycle
    localparam int NTI_DEF = 16;

    // adc magnitude width, also the width of the signed unfolded code
    localparam int NADC_DEF = 8;

    //////////////////////////////
    // bist and checker sizes
    //////////////////////////////

    // lfsr length shared by generator and checker
    localparam int NPRBS_DEF = 7;

    // error and total bit counters
    localparam int NCOUNT_DEF = 64;

endpackage
